// ==== sdio_host_top.f ====
+incdir+verilog
verilog/sdio_host_pkg.sv
verilog/sdio_crc7.sv
verilog/sdio_clkgen.sv
verilog/sdio_reg_if.sv
verilog/sdio_cmd_engine.sv
verilog/sdio_host_top.sv
tests/sdio_card_model.sv
tests/sdio_host_assertions.sv
tests/sdio_host_tb.sv

// ==== tests/sdio_host_tb.sv ====
`include "sdio_host_cfg.svh"

module sdio_host_tb
	import sdio_host_pkg::*;
();

	typedef struct packed {
		logic [5:0]  op;
		logic [31:0] arg;
		logic        rnd;     // Random argument
		rsp_type_e   rsp;
		logic [7:0]  div;
		logic        silent;
		logic        bad_crc;
		logic [3:0]  delay;
		logic [4:0]  status;  // STATUS after eot
		logic        busy_wr; // Extra writes while busy
	} case_t;

	localparam int NUM_CASES = 7;

	logic                    sys_clk;
	logic                    reset;
	logic                    cfg_valid;
	logic                    cfg_rwn;
	logic [`SDIO_ADDR_W-1:0] cfg_addr;
	logic [`SDIO_DATA_W-1:0] cfg_wdata;
	wire  [`SDIO_DATA_W-1:0] cfg_rdata;
	wire                     cfg_ready;
	wire                     eot;
	wire                     err;
	wire                     sdclk;
	wire                     sdcmd;
	wire                     sdcmd_oen;
	wire                     card_cmd;
	logic [5:0]              card_op;
	logic [31:0]             card_arg;
	logic                    card_silent;
	logic                    card_bad_crc;
	logic                    card_nocrc;
	logic [3:0]              card_delay;
	int                      card_frames;
	int                      card_errors;
	int                      errors = 0;
	int                      eot_pulses = 0;
	int                      err_pulses = 0;
	int                      total;
	int unsigned             seed_val;
	case_t                   cases [NUM_CASES];

	sdio_host_top u_sdio_host_top (
		.sys_clk_i   (sys_clk),
		.reset_i     (reset),
		.cfg_data_i  (cfg_wdata),
		.cfg_addr_i  (cfg_addr),
		.cfg_valid_i (cfg_valid),
		.cfg_rwn_i   (cfg_rwn),
		.cfg_data_o  (cfg_rdata),
		.cfg_ready_o (cfg_ready),
		.eot_o       (eot),
		.err_o       (err),
		.sdclk_o     (sdclk),
		.sdcmd_o     (sdcmd),
		.sdcmd_i     (card_cmd),
		.sdcmd_oen_o (sdcmd_oen)
	);

	sdio_card_model u_card (
		.sys_clk_i (sys_clk),
		.sdclk_i   (sdclk),
		.cmd_i     (sdcmd),
		.cmd_oen_i (sdcmd_oen),
		.cmd_o     (card_cmd),
		.exp_op_i  (card_op),
		.exp_arg_i (card_arg),
		.silent_i  (card_silent),
		.bad_crc_i (card_bad_crc),
		.nocrc_i   (card_nocrc),
		.delay_i   (card_delay),
		.frames_o  (card_frames),
		.errors_o  (card_errors)
	);

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	always @(negedge sys_clk) begin
		if (eot)
			eot_pulses++;
		if (err)
			err_pulses++;
	end

	task automatic abort_run(input string what);
		$display("Timed out waiting for %s", what);
		$display("Test failures found");
		$finish;
	endtask

	task automatic compare(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR @%0t: %s is %h, expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	task automatic bus_access(input logic rwn, input logic [4:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		int n;
		@(negedge sys_clk);
		cfg_valid = 1'b1;
		cfg_rwn = rwn;
		cfg_addr = addr;
		cfg_wdata = wdata;
		n = 0;
		do begin
			@(negedge sys_clk);
			n++;
		end while (!cfg_ready && n < 300);
		if (!cfg_ready)
			abort_run("cfg_ready_o");
		rdata = cfg_rdata;
		cfg_valid = 1'b0;
	endtask

	task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b0, addr, data, unused);
	endtask

	task automatic read_check(input string what, input logic [4:0] addr,
		input logic [31:0] expected);
		logic [31:0] data;
		bus_access(1'b1, addr, '0, data);
		compare(what, data, expected);
	endtask

	task automatic next_toggle(output int cycles);
		logic level;
		level = sdclk;
		cycles = 0;
		do begin
			@(negedge sys_clk);
			cycles++;
		end while (sdclk == level && cycles < 600);
		if (sdclk == level)
			abort_run("an sdclk_o edge");
	endtask

	task automatic check_half_periods(input logic [7:0] div);
		int cycles;
		next_toggle(cycles); // Reload edge ends a partial half period
		for (int i = 0; i < 4; i++) begin
			next_toggle(cycles);
			compare("sdclk_o half period", cycles, div + 1);
		end
	endtask

	task automatic wait_eot(output int cycles, output logic err_seen);
		cycles = 0;
		do begin
			@(negedge sys_clk);
			cycles++;
		end while (!eot && cycles < 20000);
		if (!eot)
			abort_run("eot_o");
		err_seen = err;
	endtask

	task automatic run_case(input case_t c);
		logic [31:0] arg;
		logic [31:0] op_word;
		logic        exp_err;
		logic        err_seen;
		int          cycles;
		int          frames0;
		int          eot0;
		int          err0;
		arg = c.rnd ? $urandom : c.arg;
		exp_err = c.status[STAT_TIMEOUT] | c.status[STAT_CRC] | c.status[STAT_FRAME];
		op_word = '0;
		op_word[5:0] = c.op;
		op_word[10:8] = c.rsp;
		bus_write(REG_CLKDIV, c.div);
		check_half_periods(c.div);
		card_op = c.op;
		card_arg = arg;
		card_silent = c.silent;
		card_bad_crc = c.bad_crc;
		card_nocrc = (c.rsp == RSP_48_NOCRC);
		card_delay = c.delay;
		bus_write(REG_CMD_OP, op_word);
		bus_write(REG_CMD_ARG, arg);
		frames0 = card_frames;
		eot0 = eot_pulses;
		err0 = err_pulses;
		bus_write(REG_START, '0);
		if (c.busy_wr) begin
			bus_write(REG_START, '0);
			bus_write(REG_CMD_ARG, ~arg);
		end
		wait_eot(cycles, err_seen);
		compare("err_o with eot_o", err_seen, exp_err);
		if (c.rsp == RSP_NONE)
			compare("eot_o within the command frame", cycles <= (c.div + 1) * 110, 1);
		read_check("STATUS after eot", REG_STATUS, {27'b0, c.status});
		read_check("STATUS second read", REG_STATUS, '0);
		if (!c.silent) begin
			read_check("RSP_ARG", REG_RSP_ARG, ~arg);
			read_check("RSP_IDX", REG_RSP_IDX, card_nocrc ? 32'h3f : {26'b0, c.op});
		end
		if (c.busy_wr)
			read_check("CMD_ARG after write while busy", REG_CMD_ARG, arg);
		compare("frames seen by the card", card_frames - frames0, 1);
		compare("eot_o pulses", eot_pulses - eot0, 1);
		compare("err_o pulses", err_pulses - err0, exp_err);
	endtask

	initial begin
		seed_val = $urandom(32'h3aad_cb50);
		reset = 1'b1;
		cfg_valid = 1'b0;
		cfg_rwn = 1'b1;
		cfg_addr = '0;
		cfg_wdata = '0;
		card_op = '0;
		card_arg = '0;
		card_silent = 1'b1;
		card_bad_crc = 1'b0;
		card_nocrc = 1'b0;
		card_delay = '0;
		cases[0] = '{6'd17, 32'h1234_5678, 1'b0, RSP_48, 8'd4, 1'b0, 1'b0, 4'd2, 5'h02, 1'b1};
		cases[1] = '{6'd55, 32'h0, 1'b1, RSP_48, 8'd3, 1'b0, 1'b0, 4'd5, 5'h02, 1'b0};
		cases[2] = '{6'd13, 32'h0, 1'b1, RSP_48, 8'd9, 1'b0, 1'b1, 4'd3, 5'h0a, 1'b0};
		cases[3] = '{6'd41, 32'h00ff_8000, 1'b0, RSP_48_NOCRC, 8'd0, 1'b0, 1'b0, 4'd2, 5'h02,
			1'b0};
		cases[4] = '{6'd8, 32'h0, 1'b1, RSP_48, 8'd1, 1'b1, 1'b0, 4'd0, 5'h06, 1'b0};
		cases[5] = '{6'd0, 32'hffff_ffff, 1'b0, RSP_NONE, 8'd3, 1'b1, 1'b0, 4'd0, 5'h02, 1'b0};
		cases[6] = '{6'd63, 32'h0, 1'b1, RSP_48, 8'd2, 1'b0, 1'b0, 4'd1, 5'h02, 1'b0};
		repeat (10) @(negedge sys_clk);
		reset = 1'b0;
		@(negedge sys_clk);
		compare("sdcmd_oen_o after reset", sdcmd_oen, 1);
		compare("sdcmd_o after reset", sdcmd, 1);
		compare("eot_o after reset", eot, 0);
		compare("err_o after reset", err, 0);
		read_check("STATUS after reset", REG_STATUS, '0);
		for (int i = 0; i < NUM_CASES; i++)
			run_case(cases[i]);
		total = errors + card_errors + u_sdio_host_top.u_assert.fail_cnt;
		$display("Summary: %0d testbench errors, %0d card errors, %0d assertion failures",
			errors, card_errors, u_sdio_host_top.u_assert.fail_cnt);
		if (total == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== tests/sdio_host_assertions.sv ====
module sdio_host_assertions (
	input wire sys_clk_i,
	input wire reset_i,
	input wire sdcmd_oen_i,
	input wire cmd_busy_i,
	input wire eot_i,
	input wire div_req_i,
	input wire div_ack_i
);

	int fail_cnt = 0;

	oen_only_busy: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		!sdcmd_oen_i |-> cmd_busy_i)
		else begin
			$error("CMD line driven while the command engine is idle");
			fail_cnt++;
		end

	eot_single: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		eot_i |=> !eot_i)
		else begin
			$error("eot_o high for two cycles");
			fail_cnt++;
		end

	// Req may only drop after ack
	div_req_hold: assert property (@(posedge sys_clk_i) disable iff (reset_i)
		div_req_i && !div_ack_i |=> div_req_i)
		else begin
			$error("div_req dropped before div_ack");
			fail_cnt++;
		end

endmodule

bind sdio_host_top sdio_host_assertions u_assert (
	.sys_clk_i   (sys_clk_i),
	.reset_i     (reset_i),
	.sdcmd_oen_i (sdcmd_oen_o),
	.cmd_busy_i  (s_cmd_busy),
	.eot_i       (eot_o),
	.div_req_i   (s_div_req),
	.div_ack_i   (s_div_ack)
);

// ==== tests/sdio_card_model.sv ====
module sdio_card_model (
	input  wire        sys_clk_i,
	input  wire        sdclk_i,
	input  wire        cmd_i,
	input  wire        cmd_oen_i,
	output logic       cmd_o,
	input  wire [5:0]  exp_op_i,
	input  wire [31:0] exp_arg_i,
	input  wire        silent_i,
	input  wire        bad_crc_i,
	input  wire        nocrc_i,
	input  wire [3:0]  delay_i, // sdclk falls before the response
	output int         frames_o,
	output int         errors_o
);

	logic [47:0] frame;
	logic        found;

	// SD CRC7 polynomial x^7 + x^3 + 1 MSB first
	function automatic logic [6:0] crc7(input logic [39:0] data);
		logic [6:0] crc;
		logic       fb;
		crc = '0;
		for (int i = 39; i >= 0; i--) begin
			fb = data[i] ^ crc[6];
			crc = {crc[5:0], 1'b0};
			if (fb)
				crc = crc ^ 7'h09;
		end
		return crc;
	endfunction

	task automatic check_field(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR @%0t: card saw %s %h, expected %h", $time, what, actual, expected);
			errors_o++;
		end
	endtask

	// Sample half a system cycle after the rise
	task automatic sample_bit(output logic b, output logic oen);
		@(posedge sdclk_i);
		@(negedge sys_clk_i);
		b = cmd_i;
		oen = cmd_oen_i;
	endtask

	task automatic receive_frame(output logic [47:0] f, output logic ok);
		logic b;
		logic oen;
		int   n;
		int   released;
		n = 0;
		released = 0;
		f = '0;
		do begin
			sample_bit(b, oen);
			n++;
		end while ((oen !== 1'b0 || b !== 1'b0) && n < 5000);
		ok = (oen === 1'b0 && b === 1'b0);
		if (ok) begin
			for (int i = 46; i >= 0; i--) begin
				sample_bit(b, oen);
				f[i] = b;
				if (oen !== 1'b0)
					released++;
			end
			check_field("released bits in frame", released, 0);
		end
	endtask

	task automatic send_response(input logic [47:0] f);
		logic [39:0] head;
		logic [6:0]  crc;
		logic [47:0] rsp;
		head = {2'b00, nocrc_i ? 6'h3f : f[45:40], ~f[39:8]};
		crc = nocrc_i ? 7'h7f : crc7(head);
		if (bad_crc_i)
			crc[3] = ~crc[3];
		rsp = {head, crc, 1'b1};
		repeat (delay_i) @(negedge sdclk_i);
		for (int i = 47; i >= 0; i--) begin
			@(negedge sdclk_i);
			@(negedge sys_clk_i);
			cmd_o = rsp[i];
		end
		@(negedge sdclk_i);
		@(negedge sys_clk_i);
		cmd_o = 1'b1; // Back to pull-up level
	endtask

	initial begin
		cmd_o = 1'b1;
		frames_o = 0;
		errors_o = 0;
		forever begin
			receive_frame(frame, found);
			if (found) begin
				frames_o++;
				check_field("transmit bit", frame[46], 1);
				check_field("end bit", frame[0], 1);
				check_field("CRC7", frame[7:1], crc7(frame[47:8]));
				check_field("op", frame[45:40], exp_op_i);
				check_field("argument", frame[39:8], exp_arg_i);
				if (!silent_i)
					send_response(frame);
			end else begin
				$display("Card saw no command start bit within 5000 sdclk cycles");
				errors_o++;
			end
		end
	end

endmodule

// ==== verilog/sdio_host_top.sv ====
`include "sdio_host_cfg.svh"

module sdio_host_top
	import sdio_host_pkg::*;
(
	input  wire                     sys_clk_i,
	input  wire                     reset_i,
	input  wire [`SDIO_DATA_W-1:0]  cfg_data_i,
	input  wire [`SDIO_ADDR_W-1:0]  cfg_addr_i,
	input  wire                     cfg_valid_i,
	input  wire                     cfg_rwn_i,
	output wire [`SDIO_DATA_W-1:0]  cfg_data_o,
	output wire                     cfg_ready_o,
	output wire                     eot_o,
	output wire                     err_o,
	output wire                     sdclk_o,
	output wire                     sdcmd_o,
	input  wire                     sdcmd_i,
	output wire                     sdcmd_oen_o
);

	wire [`SDIO_DIV_W-1:0]  s_div_data;
	wire                    s_div_req;
	wire                    s_div_ack;
	wire                    s_sdclk_rise;
	wire                    s_sdclk_fall;
	wire                    s_cmd_start;
	wire [5:0]              s_cmd_op;
	wire [`SDIO_DATA_W-1:0] s_cmd_arg;
	rsp_type_e              s_cmd_rsp_type;
	wire                    s_cmd_busy;
	wire                    s_cmd_done;
	wire                    s_err_timeout;
	wire                    s_err_crc;
	wire                    s_err_frame;
	wire [`SDIO_DATA_W-1:0] s_rsp_arg;
	wire [5:0]              s_rsp_idx;

	sdio_reg_if u_reg_if (
		.sys_clk_i      (sys_clk_i),
		.reset_i        (reset_i),
		.cfg_data_i     (cfg_data_i),
		.cfg_addr_i     (cfg_addr_i),
		.cfg_valid_i    (cfg_valid_i),
		.cfg_rwn_i      (cfg_rwn_i),
		.cfg_data_o     (cfg_data_o),
		.cfg_ready_o    (cfg_ready_o),
		.div_data_o     (s_div_data),
		.div_req_o      (s_div_req),
		.div_ack_i      (s_div_ack),
		.cmd_start_o    (s_cmd_start),
		.cmd_op_o       (s_cmd_op),
		.cmd_arg_o      (s_cmd_arg),
		.cmd_rsp_type_o (s_cmd_rsp_type),
		.cmd_busy_i     (s_cmd_busy),
		.cmd_done_i     (s_cmd_done),
		.err_timeout_i  (s_err_timeout),
		.err_crc_i      (s_err_crc),
		.err_frame_i    (s_err_frame),
		.rsp_arg_i      (s_rsp_arg),
		.rsp_idx_i      (s_rsp_idx),
		.eot_o          (eot_o),
		.err_o          (err_o)
	);

	sdio_clkgen u_clkgen (
		.sys_clk_i    (sys_clk_i),
		.reset_i      (reset_i),
		.div_data_i   (s_div_data),
		.div_req_i    (s_div_req),
		.div_ack_o    (s_div_ack),
		.sdclk_o      (sdclk_o),
		.sdclk_rise_o (s_sdclk_rise),
		.sdclk_fall_o (s_sdclk_fall)
	);

	sdio_cmd_engine u_cmd_engine (
		.sys_clk_i      (sys_clk_i),
		.reset_i        (reset_i),
		.sdclk_rise_i   (s_sdclk_rise),
		.sdclk_fall_i   (s_sdclk_fall),
		.cmd_start_i    (s_cmd_start),
		.cmd_op_i       (s_cmd_op),
		.cmd_arg_i      (s_cmd_arg),
		.cmd_rsp_type_i (s_cmd_rsp_type),
		.cmd_busy_o     (s_cmd_busy),
		.cmd_done_o     (s_cmd_done),
		.err_timeout_o  (s_err_timeout),
		.err_crc_o      (s_err_crc),
		.err_frame_o    (s_err_frame),
		.rsp_arg_o      (s_rsp_arg),
		.rsp_idx_o      (s_rsp_idx),
		.sdcmd_o        (sdcmd_o),
		.sdcmd_i        (sdcmd_i),
		.sdcmd_oen_o    (sdcmd_oen_o)
	);

endmodule

// ==== verilog/sdio_cmd_engine.sv ====
`include "sdio_host_cfg.svh"

module sdio_cmd_engine
	import sdio_host_pkg::*;
(
	input  wire                     sys_clk_i,
	input  wire                     reset_i,
	input  wire                     sdclk_rise_i,
	input  wire                     sdclk_fall_i,
	input  wire                     cmd_start_i,
	input  wire [5:0]               cmd_op_i,
	input  wire [`SDIO_DATA_W-1:0]  cmd_arg_i,
	input  rsp_type_e               cmd_rsp_type_i,
	output logic                    cmd_busy_o,
	output logic                    cmd_done_o,
	output logic                    err_timeout_o,
	output logic                    err_crc_o,
	output logic                    err_frame_o,
	output logic [`SDIO_DATA_W-1:0] rsp_arg_o,
	output logic [5:0]              rsp_idx_o,
	output logic                    sdcmd_o,
	input  wire                     sdcmd_i,
	output logic                    sdcmd_oen_o
);

	localparam int FRAME_BITS = `SDIO_CMD_BITS;
	localparam int CRC_START = FRAME_BITS - 8; // Bits covered by the CRC
	localparam int TO_W = $clog2(`SDIO_RSP_TIMEOUT);

	cmd_state_e             state_q;
	logic [5:0]             bit_cnt_q;
	logic [TO_W-1:0]        to_cnt_q;
	logic                   tout_q;
	logic [FRAME_BITS-1:0]  rx_sr_q;
	logic [CRC_START-1:0]   tx_frame;
	logic                   tx_bit;
	logic                   start_acc;
	logic                   sending;
	logic                   rx_shift;
	logic                   rsp_chk;
	logic                   crc_bad;
	logic                   frame_bad;
	logic [6:0]             crc_tx;
	logic [6:0]             crc_rx;

	assign start_acc = (state_q == IDLE) && cmd_start_i;
	assign sending = (state_q == SYNC) || (state_q == SEND);
	assign tx_frame = {1'b0, 1'b1, cmd_op_i, cmd_arg_i};

	// Frame bit, then CRC, then end bit
	always_comb begin
		if (bit_cnt_q < CRC_START)
			tx_bit = tx_frame[CRC_START - 1 - bit_cnt_q];
		else if (bit_cnt_q < FRAME_BITS - 1)
			tx_bit = crc_tx[FRAME_BITS - 2 - bit_cnt_q];
		else
			tx_bit = 1'b1;
	end

	assign rx_shift = sdclk_rise_i &&
		(((state_q == WAIT_RSP) && !sdcmd_i) || (state_q == RECV));

	assign rsp_chk = (cmd_rsp_type_i != RSP_NONE) && !tout_q;
	assign crc_bad = rsp_chk && (cmd_rsp_type_i == RSP_48) && (rx_sr_q[7:1] != crc_rx);
	assign frame_bad = rsp_chk && (!rx_sr_q[0] ||
		((cmd_rsp_type_i == RSP_48) && (rx_sr_q[45:40] != cmd_op_i)));

	sdio_crc7 u_crc_tx (
		.sys_clk_i (sys_clk_i),
		.reset_i   (reset_i),
		.clear_i   (start_acc),
		.bit_en_i  (sdclk_fall_i && sending && (bit_cnt_q < CRC_START)),
		.bit_i     (tx_bit),
		.crc_o     (crc_tx)
	);

	sdio_crc7 u_crc_rx (
		.sys_clk_i (sys_clk_i),
		.reset_i   (reset_i),
		.clear_i   (start_acc),
		.bit_en_i  (rx_shift && (bit_cnt_q < CRC_START)),
		.bit_i     (sdcmd_i),
		.crc_o     (crc_rx)
	);

	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			state_q <= IDLE;
			bit_cnt_q <= '0;
			to_cnt_q <= '0;
			tout_q <= 1'b0;
			cmd_done_o <= 1'b0;
			err_timeout_o <= 1'b0;
			err_crc_o <= 1'b0;
			err_frame_o <= 1'b0;
			sdcmd_o <= 1'b1;
			sdcmd_oen_o <= 1'b1;
		end else begin
			cmd_done_o <= 1'b0;
			case (state_q)
				IDLE: begin
					if (cmd_start_i) begin
						bit_cnt_q <= '0;
						to_cnt_q <= '0;
						tout_q <= 1'b0;
						state_q <= SYNC;
					end
				end
				SYNC, SEND: begin
					if (sdclk_fall_i) begin
						if (bit_cnt_q == FRAME_BITS) begin
							sdcmd_o <= 1'b1; // Release after the end bit
							sdcmd_oen_o <= 1'b1;
							bit_cnt_q <= '0;
							if (cmd_rsp_type_i == RSP_NONE)
								state_q <= DONE;
							else
								state_q <= WAIT_RSP;
						end else begin
							sdcmd_o <= tx_bit;
							sdcmd_oen_o <= 1'b0;
							bit_cnt_q <= bit_cnt_q + 6'd1;
							state_q <= SEND;
						end
					end
				end
				WAIT_RSP: begin
					if (sdclk_rise_i) begin
						if (!sdcmd_i) begin
							bit_cnt_q <= 6'd1; // Start bit counts as the first
							state_q <= RECV;
						end else if (to_cnt_q == TO_W'(`SDIO_RSP_TIMEOUT - 1)) begin
							tout_q <= 1'b1;
							state_q <= DONE;
						end else begin
							to_cnt_q <= to_cnt_q + 1'b1;
						end
					end
				end
				RECV: begin
					if (sdclk_rise_i) begin
						bit_cnt_q <= bit_cnt_q + 6'd1;
						if (bit_cnt_q == FRAME_BITS - 1)
							state_q <= DONE;
					end
				end
				DONE: begin
					cmd_done_o <= 1'b1;
					err_timeout_o <= tout_q;
					err_crc_o <= crc_bad;
					err_frame_o <= frame_bad;
					state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (start_acc)
			rx_sr_q <= '0;
		else if (rx_shift)
			rx_sr_q <= {rx_sr_q[FRAME_BITS-2:0], sdcmd_i};
		if (state_q == DONE) begin
			rsp_arg_o <= rx_sr_q[39:8];
			rsp_idx_o <= rx_sr_q[45:40];
		end
	end

	assign cmd_busy_o = (state_q != IDLE);

endmodule

// ==== verilog/sdio_reg_if.sv ====
`include "sdio_host_cfg.svh"

module sdio_reg_if
	import sdio_host_pkg::*;
(
	input  wire                     sys_clk_i,
	input  wire                     reset_i,
	input  wire [`SDIO_DATA_W-1:0]  cfg_data_i,
	input  wire [`SDIO_ADDR_W-1:0]  cfg_addr_i,
	input  wire                     cfg_valid_i,
	input  wire                     cfg_rwn_i,
	output logic [`SDIO_DATA_W-1:0] cfg_data_o,
	output logic                    cfg_ready_o,
	output logic [`SDIO_DIV_W-1:0]  div_data_o,
	output logic                    div_req_o,
	input  wire                     div_ack_i,
	output logic                    cmd_start_o,
	output logic [5:0]              cmd_op_o,
	output logic [`SDIO_DATA_W-1:0] cmd_arg_o,
	output rsp_type_e               cmd_rsp_type_o,
	input  wire                     cmd_busy_i,
	input  wire                     cmd_done_i,
	input  wire                     err_timeout_i,
	input  wire                     err_crc_i,
	input  wire                     err_frame_i,
	input  wire [`SDIO_DATA_W-1:0]  rsp_arg_i,
	input  wire [5:0]               rsp_idx_i,
	output logic                    eot_o,
	output logic                    err_o
);

	logic                          acc;
	logic                          wr;
	logic                          busy;
	logic                          clkdiv_wr;
	logic                          rd_status;
	logic [`SDIO_DATA_W-1:0]       status_w;
	logic [`SDIO_DATA_W-1:0]       rdata_w;
	logic [STAT_FRAME:STAT_EOT]    sticky_q;
	logic [STAT_FRAME:STAT_EOT]    sticky_set;

	// A CLKDIV write stalls until the previous reload has fully completed
	assign clkdiv_wr = cfg_valid_i & ~cfg_rwn_i & (cfg_addr_i == REG_CLKDIV);
	assign acc = cfg_valid_i & ~cfg_ready_o & ~(clkdiv_wr & (div_req_o | div_ack_i));
	assign wr = acc & ~cfg_rwn_i;
	assign rd_status = acc & cfg_rwn_i & (cfg_addr_i == REG_STATUS);
	assign busy = cmd_busy_i | cmd_start_o; // Covers the cycle before the engine reacts

	assign sticky_set = {err_frame_i, err_crc_i, err_timeout_i, 1'b1} & {4{cmd_done_i}};

	assign eot_o = cmd_done_i;
	assign err_o = cmd_done_i & (err_timeout_i | err_crc_i | err_frame_i);

	always_comb begin
		status_w = '0;
		status_w[STAT_BUSY] = busy;
		status_w[STAT_FRAME:STAT_EOT] = sticky_q;
	end

	always_comb begin
		rdata_w = '0;
		case (reg_addr_e'(cfg_addr_i))
			REG_CMD_OP: begin
				rdata_w[5:0] = cmd_op_o;
				rdata_w[10:8] = cmd_rsp_type_o;
			end
			REG_CMD_ARG: rdata_w = cmd_arg_o;
			REG_CLKDIV:  rdata_w[`SDIO_DIV_W-1:0] = div_data_o;
			REG_STATUS:  rdata_w = status_w;
			REG_RSP_ARG: rdata_w = rsp_arg_i;
			REG_RSP_IDX: rdata_w[5:0] = rsp_idx_i;
			default:     rdata_w = '0;
		endcase
	end

	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			cfg_ready_o <= 1'b0;
			cmd_start_o <= 1'b0;
			div_req_o <= 1'b0;
			div_data_o <= `SDIO_DIV_W'(`SDIO_DIV_RESET);
			cmd_op_o <= '0;
			cmd_arg_o <= '0;
			cmd_rsp_type_o <= RSP_NONE;
			sticky_q <= '0;
		end else begin
			cfg_ready_o <= acc;
			cmd_start_o <= wr && (cfg_addr_i == REG_START) && !busy;
			if (div_req_o && div_ack_i)
				div_req_o <= 1'b0;
			if (wr) begin
				case (reg_addr_e'(cfg_addr_i))
					REG_CMD_OP: begin
						if (!busy) begin
							cmd_op_o <= cfg_data_i[5:0];
							cmd_rsp_type_o <= rsp_type_e'(cfg_data_i[10:8]);
						end
					end
					REG_CMD_ARG: begin
						if (!busy)
							cmd_arg_o <= cfg_data_i;
					end
					REG_CLKDIV: begin
						div_data_o <= cfg_data_i[`SDIO_DIV_W-1:0];
						div_req_o <= 1'b1;
					end
					default: ;
				endcase
			end
			// New events win over the clear of a status read
			sticky_q <= (sticky_q & ~{4{rd_status}}) | sticky_set;
		end
	end

	always_ff @(posedge sys_clk_i) begin
		if (acc && cfg_rwn_i)
			cfg_data_o <= rdata_w;
	end

endmodule

// ==== verilog/sdio_clkgen.sv ====
`include "sdio_host_cfg.svh"

module sdio_clkgen (
	input  wire                    sys_clk_i,
	input  wire                    reset_i,
	input  wire [`SDIO_DIV_W-1:0]  div_data_i,
	input  wire                    div_req_i,
	output logic                   div_ack_o,
	output logic                   sdclk_o,
	output logic                   sdclk_rise_o,
	output logic                   sdclk_fall_o
);

	logic [`SDIO_DIV_W-1:0] cnt_q;
	logic [`SDIO_DIV_W-1:0] div_q; // Active divider
	logic                   boundary;

	assign boundary = (cnt_q == div_q);

	always_ff @(posedge sys_clk_i) begin
		if (reset_i) begin
			cnt_q <= '0;
			div_q <= `SDIO_DIV_W'(`SDIO_DIV_RESET);
			sdclk_o <= 1'b0;
			sdclk_rise_o <= 1'b0;
			sdclk_fall_o <= 1'b0;
			div_ack_o <= 1'b0;
		end else begin
			sdclk_rise_o <= boundary & ~sdclk_o;
			sdclk_fall_o <= boundary & sdclk_o;
			if (boundary) begin
				cnt_q <= '0;
				sdclk_o <= ~sdclk_o;
				// Reload only here so no half period is cut short
				if (div_req_i && !div_ack_o) begin
					div_q <= div_data_i;
					div_ack_o <= 1'b1;
				end
			end else begin
				cnt_q <= cnt_q + 1'b1;
			end
			if (div_ack_o && !div_req_i)
				div_ack_o <= 1'b0; // Last phase of the handshake
		end
	end

endmodule

// ==== verilog/sdio_crc7.sv ====
module sdio_crc7 (
	input  wire        sys_clk_i,
	input  wire        reset_i,
	input  wire        clear_i,
	input  wire        bit_en_i,
	input  wire        bit_i,
	output logic [6:0] crc_o
);

	logic fb;

	assign fb = bit_i ^ crc_o[6];

	// x^7 + x^3 + 1 taken MSB first
	always_ff @(posedge sys_clk_i) begin
		if (reset_i || clear_i) begin
			crc_o <= '0;
		end else if (bit_en_i) begin
			crc_o <= {crc_o[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
		end
	end

endmodule

// ==== verilog/sdio_host_pkg.sv ====
package sdio_host_pkg;

	// Response kind in the 3-bit CMD_OP field
	typedef enum logic [2:0] {
		RSP_NONE     = 3'd0,
		RSP_48       = 3'd1, // R1 style
		RSP_48_NOCRC = 3'd2  // R3 style without index or CRC
	} rsp_type_e;

	typedef enum logic [2:0] {
		IDLE,
		SYNC,
		SEND,
		WAIT_RSP,
		RECV,
		DONE
	} cmd_state_e;

	typedef enum logic [4:0] {
		REG_CMD_OP  = 5'd0,
		REG_CMD_ARG = 5'd1,
		REG_CLKDIV  = 5'd2,
		REG_START   = 5'd3,
		REG_STATUS  = 5'd4,
		REG_RSP_ARG = 5'd5,
		REG_RSP_IDX = 5'd6
	} reg_addr_e;

	// Bit positions in REG_STATUS
	typedef enum int unsigned {
		STAT_BUSY    = 0,
		STAT_EOT     = 1,
		STAT_TIMEOUT = 2,
		STAT_CRC     = 3,
		STAT_FRAME   = 4
	} rsp_stat_e;

endpackage

// ==== verilog/sdio_host_cfg.svh ====
`ifndef SDIO_HOST_CFG_SVH
`define SDIO_HOST_CFG_SVH

`define SDIO_DATA_W 32
`define SDIO_ADDR_W 5
`define SDIO_DIV_W 8

// Half period of divider+1 cycles
`define SDIO_DIV_RESET 4

`define SDIO_CMD_BITS 48
`define SDIO_RSP_TIMEOUT 64

`endif
